//--- project.f
src/alu_pkg.sv
src/alu_cmp.sv
src/alu_mul.sv
src/alu_div.sv
src/alu.sv
sim/alu_assertions.sv
sim/tb_alu.sv

//--- Bender.yml
package:
  name: int_exec_lane

sources:
  # Package first, then the units, then the lane top level
  - src/alu_pkg.sv
  - src/alu_cmp.sv
  - src/alu_mul.sv
  - src/alu_div.sv
  - src/alu.sv
  - target: simulation
    files:
      - sim/alu_assertions.sv
      - sim/tb_alu.sv

//--- sim/tb_alu.sv
// Self-checking testbench for the integer execution lane
// Table rows run in order before random multiply and divide pairs
// Operands stay stable from ld until the done level is seen
`timescale 1ns/1ns

module tb_alu;
	import alu_pkg::*;

	localparam int k_one = 0;
	localparam int k_mul = 1;
	localparam int k_div = 2;
	localparam int max_entries = 128;
	localparam int done_limit = 100;
	// Immediate, target and cause shared by every table row
	localparam logic [xlen-1:0] imm_val = 64'h48;
	localparam logic [xlen-1:0] tgt_val = 64'h7;
	localparam cause_t cause_val = 8'h41;
	// All six orderings of three value indices with two bits per index
	localparam logic [35:0] perm_code = {6'b00_01_10, 6'b00_10_01, 6'b01_00_10,
		6'b01_10_00, 6'b10_00_01, 6'b10_01_00};

	logic clk;
	logic rst;
	logic ld;
	alu_op_t op;
	logic [2:0] sub;
	cause_t cause;
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] c;
	logic [xlen-1:0] i;
	logic [xlen-1:0] t;
	logic [xlen-1:0] o;
	cause_t exc_o;
	logic mul_done;
	logic div_done;
	logic div_dbz;

	// Stimulus and expected values with one row per index
	alu_op_t e_op [max_entries];
	logic [2:0] e_sub [max_entries];
	logic [xlen-1:0] e_a [max_entries];
	logic [xlen-1:0] e_b [max_entries];
	logic [xlen-1:0] e_c [max_entries];
	logic [xlen-1:0] e_o [max_entries];
	cause_t e_exc [max_entries];
	int e_kind [max_entries];
	int n_entries;
	int errors;
	int checks;
	int timeouts;

	alu dut (
		.clk(clk), .rst(rst), .ld(ld), .op(op), .sub(sub), .cause(cause),
		.a(a), .b(b), .c(c), .i(i), .t(t), .o(o), .exc_o(exc_o),
		.mul_done(mul_done), .div_done(div_done), .div_dbz(div_dbz)
	);

	bind alu alu_assertions u_assertions (
		.clk(clk), .rst(rst), .ld(ld), .mul_done(mul_done),
		.div_done(div_done), .exc_o(exc_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// Reference models
	// ========================================
	// Full 128-bit products that are signed or unsigned by operation
	function automatic logic [xlen-1:0] mul_model(input alu_op_t op_v,
		input logic [xlen-1:0] x, input logic [xlen-1:0] y);
		logic [2*xlen-1:0] ps;
		logic [2*xlen-1:0] pu;
		ps = $signed({{xlen{x[xlen-1]}}, x}) * $signed({{xlen{y[xlen-1]}}, y});
		pu = {{xlen{1'b0}}, x} * {{xlen{1'b0}}, y};
		if (op_v == op_mulh)
			return ps[2*xlen-1:xlen];
		if (op_v == op_mul)
			return ps[xlen-1:0];
		return pu[xlen-1:0];
	endfunction

	// Truncating division on magnitudes; remainder follows the dividend
	function automatic logic [xlen-1:0] div_model(input alu_op_t op_v,
		input logic [xlen-1:0] x, input logic [xlen-1:0] y);
		logic sg;
		logic [xlen-1:0] xm;
		logic [xlen-1:0] ym;
		logic [xlen-1:0] qm;
		logic [xlen-1:0] rm;
		sg = (op_v == op_div) || (op_v == op_mod);
		xm = (sg && x[xlen-1]) ? -x : x;
		ym = (sg && y[xlen-1]) ? -y : y;
		qm = xm / ym;
		rm = xm % ym;
		if (sg && (x[xlen-1] ^ y[xlen-1]))
			qm = -qm;
		if (sg && x[xlen-1])
			rm = -rm;
		return ((op_v == op_div) || (op_v == op_divu)) ? qm : rm;
	endfunction

	// ========================================
	// Drive and check helpers
	// ========================================
	task automatic compare(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp_v);
		checks++;
		if (got !== exp_v)
		begin
			errors++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got);
		end
	endtask

	// Polls on falling edges until the unit's done level is high
	task automatic wait_done(input int kind_v);
		int cycles;
		logic lvl;
		cycles = 0;
		lvl = (kind_v == k_mul) ? mul_done : div_done;
		while (!lvl && cycles < done_limit)
		begin
			@(negedge clk);
			cycles++;
			lvl = (kind_v == k_mul) ? mul_done : div_done;
		end
		if (!lvl)
		begin
			timeouts++;
			errors++;
			$display("Timeout at %0t: %s done level did not rise within %0d cycles",
				$time, (kind_v == k_mul) ? "multiplier" : "divider", done_limit);
		end
	endtask

	// Called on a falling edge and returns on the falling edge of the check
	task automatic run_op(input alu_op_t op_v, input logic [2:0] sub_v,
		input logic [xlen-1:0] a_v, input logic [xlen-1:0] b_v,
		input logic [xlen-1:0] c_v, input logic [xlen-1:0] o_v,
		input cause_t exc_v, input int kind_v);
		op = op_v;
		sub = sub_v;
		cause = cause_val;
		a = a_v;
		b = b_v;
		c = c_v;
		i = imm_val;
		t = tgt_val;
		if (kind_v == k_one)
			@(negedge clk);
		else
		begin
			ld = 1'b1;
			@(negedge clk);
			ld = 1'b0;
			wait_done(kind_v);
			// Result lands one edge after done
			@(negedge clk);
			if (kind_v == k_div)
				compare("div_dbz", div_dbz, b_v == '0);
		end
		compare("o", o, o_v);
		compare("exc_o", exc_o, exc_v);
	endtask

	task automatic add_entry(input alu_op_t op_v, input logic [2:0] sub_v,
		input logic [xlen-1:0] a_v, input logic [xlen-1:0] b_v,
		input logic [xlen-1:0] c_v, input logic [xlen-1:0] o_v,
		input cause_t exc_v, input int kind_v);
		e_op[n_entries] = op_v;
		e_sub[n_entries] = sub_v;
		e_a[n_entries] = a_v;
		e_b[n_entries] = b_v;
		e_c[n_entries] = c_v;
		e_o[n_entries] = o_v;
		e_exc[n_entries] = exc_v;
		e_kind[n_entries] = kind_v;
		n_entries++;
	endtask

	// ========================================
	// Stimulus table
	// ========================================
	task automatic build_table();
		logic [xlen-1:0] mm_v [3];
		logic [5:0] pc;
		int p;
		// Three-input ops with one entry per comb code
		add_entry(op_add3, 3'd3, 64'd100, 64'd23, 64'd7, 64'd130, flt_none, k_one);
		add_entry(op_add3, 3'd0, 64'hF0, 64'h0F, 64'h3C, 64'h3C, flt_none, k_one);
		add_entry(op_sub, 3'd2, 64'h1000, 64'd1, 64'hFF, 64'hF00, flt_none, k_one);
		add_entry(op_sub, 3'd3, 64'd5, 64'd10, 64'd2, -64'd3, flt_none, k_one);
		add_entry(op_and3, 3'd1, 64'hFF00, 64'h0FF0, 64'h000F, 64'h0F0F, flt_none, k_one);
		add_entry(op_or3, 3'd0, 64'hF000, 64'h000F, 64'hFF0F, 64'hF00F, flt_none, k_one);
		add_entry(op_eor3, 3'd3, 64'hFF, 64'h0F, 64'h10, 64'h100, flt_none, k_one);
		// Shifts by the register amount in c and by immediate 0x48 giving 8
		add_entry(op_shl, 3'd0, 64'd1, 64'd0, 64'd4, 64'h10, flt_none, k_one);
		add_entry(op_shl, 3'd4, 64'd1, 64'd0, 64'd4, 64'h100, flt_none, k_one);
		add_entry(op_shr, 3'd0, 64'h8000_0000_0000_0000, 64'd0, 64'd8,
			64'h0080_0000_0000_0000, flt_none, k_one);
		add_entry(op_asr, 3'd4, 64'h8000_0000_0000_0000, 64'd0, 64'd0,
			64'hFF80_0000_0000_0000, flt_none, k_one);
		add_entry(op_asr, 3'd0, 64'h7000_0000_0000_0000, 64'd0, 64'h44,
			64'h0700_0000_0000_0000, flt_none, k_one);
		add_entry(op_addi, 3'd0, 64'd10, 64'd0, 64'd0, 64'h52, flt_none, k_one);
		add_entry(op_mov, 3'd0, 64'h1234, 64'd0, 64'd0, 64'h1234, flt_none, k_one);
		add_entry(op_nop, 3'd0, 64'h1234, 64'd0, 64'd0, 64'h7, flt_none, k_one);
		add_entry(alu_op_t'(5'd30), 3'd0, 64'd1, 64'd2, 64'd3,
			64'hDEAD_DEAD_DEAD_DEAD, flt_none, k_one);
		// Compare flag words
		add_entry(op_cmp, 3'd0, 64'd5, 64'd7, 64'd0, 64'h3E, flt_none, k_one);
		add_entry(op_cmp, 3'd0, -64'd1, 64'd1, 64'd0, 64'h0E, flt_none, k_one);
		add_entry(op_cmp, 3'd0, 64'd9, 64'd9, 64'd0, 64'hA9, flt_none, k_one);
		add_entry(op_cmp, 3'd0, 64'd1, -64'd1, 64'd0, 64'hF2, flt_none, k_one);
		// Set with a negative a that is large unsigned so lt and ltu differ
		add_entry(op_set, 3'd0, -64'd1, 64'd1, 64'hC, 64'h7, flt_none, k_one);
		add_entry(op_set, 3'd1, -64'd1, 64'd1, 64'hC, 64'hC, flt_none, k_one);
		add_entry(op_set, 3'd2, -64'd1, 64'd1, 64'hC, 64'hC, flt_none, k_one);
		add_entry(op_set, 3'd3, -64'd1, 64'd1, 64'hC, 64'hC, flt_none, k_one);
		add_entry(op_set, 3'd4, -64'd1, 64'd1, 64'hC, 64'h7, flt_none, k_one);
		add_entry(op_set, 3'd5, -64'd1, 64'd1, 64'hC, 64'h7, flt_none, k_one);
		add_entry(op_zset, 3'd0, 64'd3, 64'd3, 64'hC, 64'hC, flt_none, k_one);
		add_entry(op_zset, 3'd1, 64'd3, 64'd3, 64'hC, 64'd0, flt_none, k_one);
		add_entry(op_zset, 3'd2, 64'd3, 64'd3, 64'hC, 64'd0, flt_none, k_one);
		add_entry(op_zset, 3'd3, 64'd3, 64'd3, 64'hC, 64'hC, flt_none, k_one);
		add_entry(op_zset, 3'd4, 64'd3, 64'd3, 64'hC, 64'd0, flt_none, k_one);
		add_entry(op_zset, 3'd5, 64'd3, 64'd3, 64'hC, 64'hC, flt_none, k_one);
		// Signed order is v0 < v1 < v2 and unsigned order is v1 < v2 < v0
		mm_v[0] = -64'd5;
		mm_v[1] = 64'd3;
		mm_v[2] = 64'd10;
		for (p = 0; p < 6; p++)
		begin
			pc = perm_code[6*p +: 6];
			add_entry(op_minmax, 3'd0, mm_v[pc[5:4]], mm_v[pc[3:2]], mm_v[pc[1:0]],
				mm_v[0], flt_none, k_one);
			add_entry(op_minmax, 3'd1, mm_v[pc[5:4]], mm_v[pc[3:2]], mm_v[pc[1:0]],
				mm_v[2], flt_none, k_one);
			add_entry(op_minmax, 3'd2, mm_v[pc[5:4]], mm_v[pc[3:2]], mm_v[pc[1:0]],
				mm_v[1], flt_none, k_one);
			add_entry(op_minmax, 3'd4, mm_v[pc[5:4]], mm_v[pc[3:2]], mm_v[pc[1:0]],
				mm_v[1], flt_none, k_one);
			add_entry(op_minmax, 3'd5, mm_v[pc[5:4]], mm_v[pc[3:2]], mm_v[pc[1:0]],
				mm_v[0], flt_none, k_one);
			add_entry(op_minmax, 3'd6, mm_v[pc[5:4]], mm_v[pc[3:2]], mm_v[pc[1:0]],
				mm_v[2], flt_none, k_one);
		end
		// Multiplier low and high halves
		add_entry(op_mul, 3'd0, -64'd3, 64'd7, 64'd0, -64'd21, flt_none, k_mul);
		add_entry(op_mulh, 3'd0, -64'd3, 64'd7, 64'd0, -64'd1, flt_none, k_mul);
		add_entry(op_mulu, 3'd0, -64'd1, 64'd2, 64'd0, -64'd2, flt_none, k_mul);
		add_entry(op_mulh, 3'd0, 64'h4000_0000_0000_0000, 64'd4, 64'd0, 64'd1, flt_none, k_mul);
		add_entry(op_mul, 3'd0, 64'h1_0000_0001, 64'h1_0000_0001, 64'd0,
			64'h2_0000_0001, flt_none, k_mul);
		// Divider truncating toward zero followed by zero divisors
		add_entry(op_div, 3'd0, -64'd7, 64'd2, 64'd0, -64'd3, flt_none, k_div);
		add_entry(op_mod, 3'd0, -64'd7, 64'd2, 64'd0, -64'd1, flt_none, k_div);
		add_entry(op_div, 3'd0, 64'd7, -64'd2, 64'd0, -64'd3, flt_none, k_div);
		add_entry(op_mod, 3'd0, 64'd7, -64'd2, 64'd0, 64'd1, flt_none, k_div);
		add_entry(op_divu, 3'd0, 64'd100, 64'd7, 64'd0, 64'd14, flt_none, k_div);
		add_entry(op_modu, 3'd0, 64'd100, 64'd7, 64'd0, 64'd2, flt_none, k_div);
		add_entry(op_div, 3'd0, 64'd5, 64'd0, 64'd0, -64'd1, flt_dbz, k_div);
		add_entry(op_divu, 3'd0, 64'd5, 64'd0, 64'd0, -64'd1, flt_none, k_div);
		add_entry(op_modu, 3'd0, 64'h55, 64'd0, 64'd0, 64'h55, flt_none, k_div);
		// Range and equality checks pass a through
		add_entry(op_chk, 3'd0, 64'd5, 64'd5, 64'd10, 64'd5, flt_none, k_one);
		add_entry(op_chk, 3'd0, 64'd10, 64'd5, 64'd10, 64'd10, cause_val, k_one);
		add_entry(op_chk, 3'd0, 64'd4, 64'd5, 64'd10, 64'd4, cause_val, k_one);
		add_entry(op_chk, 3'd0, 64'd3, -64'd16, 64'd10, 64'd3, cause_val, k_one);
		add_entry(op_chk, 3'd1, 64'd10, 64'd5, 64'd10, 64'd10, flt_none, k_one);
		add_entry(op_chk, 3'd1, 64'd11, 64'd5, 64'd10, 64'd11, cause_val, k_one);
		add_entry(op_chk, 3'd1, 64'd5, 64'd5, 64'd10, 64'd5, flt_none, k_one);
		add_entry(op_chk, 3'd1, 64'd4, 64'd5, 64'd10, 64'd4, cause_val, k_one);
		add_entry(op_chk, 3'd2, 64'h77, 64'd0, 64'h77, 64'h77, flt_none, k_one);
		add_entry(op_chk, 3'd2, 64'h77, 64'd0, 64'h78, 64'h77, cause_val, k_one);
		add_entry(op_chk, 3'd3, 64'd5, 64'd5, 64'd10, 64'd5, flt_unimp, k_one);
		add_entry(op_chk, 3'd7, 64'd5, 64'd5, 64'd10, 64'd5, flt_unimp, k_one);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin
		int n;
		int unsigned seed_ret;
		logic [xlen-1:0] ra;
		logic [xlen-1:0] rb;
		alu_op_t rop;
		seed_ret = $urandom(32'h16290bde);
		errors = 0;
		checks = 0;
		timeouts = 0;
		n_entries = 0;
		rst = 1'b1;
		ld = 1'b0;
		op = op_nop;
		sub = 3'd0;
		cause = flt_none;
		a = '0;
		b = '0;
		c = '0;
		i = '0;
		t = '0;
		build_table();
		repeat (10) @(negedge clk);
		rst = 1'b0;
		// Values left by reset
		compare("o", o, '0);
		compare("exc_o", exc_o, flt_none);
		compare("mul_done", mul_done, 1'b0);
		compare("div_done", div_done, 1'b1);
		compare("div_dbz", div_dbz, 1'b0);
		for (n = 0; n < n_entries; n++)
			run_op(e_op[n], e_sub[n], e_a[n], e_b[n], e_c[n], e_o[n], e_exc[n], e_kind[n]);
		// Random pairs with the divisor shrunk so quotients vary in size
		for (n = 0; n < 20; n++)
		begin
			ra = {$urandom, $urandom};
			rb = {$urandom, $urandom};
			case ($urandom % 3)
			0:       rop = op_mul;
			1:       rop = op_mulu;
			default: rop = op_mulh;
			endcase
			run_op(rop, 3'd0, ra, rb, 64'd0, mul_model(rop, ra, rb), flt_none, k_mul);
			rb = rb >> ($urandom % 64);
			if (rb == '0)
				rb = 64'd1;
			case ($urandom % 4)
			0:       rop = op_div;
			1:       rop = op_mod;
			2:       rop = op_divu;
			default: rop = op_modu;
			endcase
			run_op(rop, 3'd0, ra, rb, 64'd0, div_model(rop, ra, rb), flt_none, k_div);
		end
		$display("Checks run: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- sim/alu_assertions.sv
// Control-level checks for the execution lane, bound into alu
// The latency check assumes ld is not pulsed again before mul_done rises
`timescale 1ns/1ns

module alu_assertions (
	input logic clk,
	input logic rst,
	input logic ld,
	input logic mul_done,
	input logic div_done,
	input alu_pkg::cause_t exc_o
);
	import alu_pkg::*;

	// Multiplier level drops on the ld edge
	mul_drop: assert property (@(posedge clk) disable iff (rst) ld |=> !mul_done)
		else $error("mul_done still high on the edge after ld");

	// Counter fills after mul_latency quiet cycles
	mul_rise: assert property (@(posedge clk) disable iff (rst)
		ld ##1 (!ld [*mul_latency]) |=> mul_done)
		else $error("mul_done not high mul_latency cycles after ld");

	// Divider reports busy right after loading
	div_drop: assert property (@(posedge clk) disable iff (rst) ld |=> !div_done)
		else $error("div_done still high on the edge after ld");

	// Cause register clears under reset
	exc_clear: assert property (@(posedge clk) rst |=> exc_o == flt_none)
		else $error("exc_o not cleared by reset");

endmodule

//--- src/alu.sv
// Integer execution lane; single-cycle ops show in o one edge after the inputs
// Multiply and divide need op and operands held from ld until the done level
// and present their result one edge after done rises
`timescale 1ns/1ns

module alu (
	input logic clk,
	input logic rst,
	input logic ld,
	input alu_pkg::alu_op_t op,
	input logic [2:0] sub,
	input alu_pkg::cause_t cause,
	input logic [alu_pkg::xlen-1:0] a,
	input logic [alu_pkg::xlen-1:0] b,
	input logic [alu_pkg::xlen-1:0] c,
	input logic [alu_pkg::xlen-1:0] i,
	input logic [alu_pkg::xlen-1:0] t,
	output logic [alu_pkg::xlen-1:0] o,
	output alu_pkg::cause_t exc_o,
	output logic mul_done,
	output logic div_done,
	output logic div_dbz
);
	import alu_pkg::*;

	logic [7:0] flags_ab;
	logic [7:0] flags_ac;
	logic [7:0] flags_bc;
	logic sgn;
	logic [xlen-1:0] prod_lo;
	logic [xlen-1:0] prod_hi;
	logic [xlen-1:0] div_q;
	logic [xlen-1:0] div_r;
	logic [shamt_w-1:0] sh_amt;
	logic cond_hit;
	logic lt_ab, lt_ac, lt_bc;
	logic gt_ab, gt_ac, gt_bc;
	logic a_mid, b_mid;
	logic [xlen-1:0] minmax_o;
	logic [xlen-1:0] nxt_o;
	cause_t nxt_exc;

	// Join the a/b result with c
	function automatic logic [xlen-1:0] comb3(input logic [xlen-1:0] x,
		input logic [xlen-1:0] y, input comb_t code);
		case (code)
		comb_and: return x & y;
		comb_or:  return x | y;
		comb_xor: return x ^ y;
		default:  return x + y;
		endcase
	endfunction

	// ========================================
	// Arithmetic units
	// ========================================
	// One comparator per operand pair; a/c also serves the range checks
	alu_cmp u_cmp_ab (.a(a), .b(b), .flags(flags_ab));
	alu_cmp u_cmp_ac (.a(a), .b(c), .flags(flags_ac));
	alu_cmp u_cmp_bc (.a(b), .b(c), .flags(flags_bc));

	assign sgn = (op == op_mul) || (op == op_mulh) || (op == op_div) || (op == op_mod);

	alu_mul u_mul (
		.clk(clk), .rst(rst), .ld(ld), .sgn(sgn), .a(a), .b(b),
		.prod_lo(prod_lo), .prod_hi(prod_hi), .mul_done(mul_done)
	);

	alu_div u_div (
		.clk(clk), .rst(rst), .ld(ld), .sgn(sgn), .a(a), .b(b),
		.q(div_q), .r(div_r), .dbz(div_dbz), .done(div_done)
	);

	// Immediate amount when sub[2] is set, else register c
	assign sh_amt = sub[2] ? i[shamt_w-1:0] : c[shamt_w-1:0];

	// Condition for set and zset, unused codes never hold
	always_comb
	begin
		case (cond_t'(sub))
		cond_eq:  cond_hit = flags_ab[flag_eq];
		cond_ne:  cond_hit = flags_ab[flag_ne];
		cond_lt:  cond_hit = flags_ab[flag_lt];
		cond_le:  cond_hit = flags_ab[flag_le];
		cond_ltu: cond_hit = flags_ab[flag_ltu];
		cond_leu: cond_hit = flags_ab[flag_leu];
		default:  cond_hit = 1'b0;
		endcase
	end

	// ========================================
	// Three-way min / max / mid
	// ========================================
	// sub[2] picks the unsigned flags
	always_comb
	begin
		lt_ab = sub[2] ? flags_ab[flag_ltu] : flags_ab[flag_lt];
		lt_ac = sub[2] ? flags_ac[flag_ltu] : flags_ac[flag_lt];
		lt_bc = sub[2] ? flags_bc[flag_ltu] : flags_bc[flag_lt];
		gt_ab = sub[2] ? !flags_ab[flag_leu] : flags_ab[flag_gt];
		gt_ac = sub[2] ? !flags_ac[flag_leu] : flags_ac[flag_gt];
		gt_bc = sub[2] ? !flags_bc[flag_leu] : flags_bc[flag_gt];
		// Median test tolerates ties on either side
		a_mid = (!lt_ab && !gt_ac) || (!gt_ab && !lt_ac);
		b_mid = (!gt_ab && !gt_bc) || (!lt_ab && !lt_bc);
		case (sub[1:0])
		2'd0:    minmax_o = (lt_ab && lt_ac) ? a : (lt_bc ? b : c);
		2'd1:    minmax_o = (gt_ab && gt_ac) ? a : (gt_bc ? b : c);
		2'd2:    minmax_o = a_mid ? a : (b_mid ? b : c);
		default: minmax_o = dead_word;
		endcase
	end

	// ========================================
	// Result select
	// ========================================
	always_comb
	begin
		nxt_o = dead_word;
		nxt_exc = flt_none;
		case (op)
		// Subtract combines with c like the other three-input ops
		op_add3:   nxt_o = comb3(a + b, c, comb_t'(sub[1:0]));
		op_sub:    nxt_o = comb3(a - b, c, comb_t'(sub[1:0]));
		op_and3:   nxt_o = comb3(a & b, c, comb_t'(sub[1:0]));
		op_or3:    nxt_o = comb3(a | b, c, comb_t'(sub[1:0]));
		op_eor3:   nxt_o = comb3(a ^ b, c, comb_t'(sub[1:0]));
		op_cmp:    nxt_o = {{(xlen - 8){1'b0}}, flags_ab};
		op_shl:    nxt_o = a << sh_amt;
		op_shr:    nxt_o = a >> sh_amt;
		op_asr:    nxt_o = $unsigned($signed(a) >>> sh_amt);
		op_set:    nxt_o = cond_hit ? c : t;
		op_zset:   nxt_o = cond_hit ? c : '0;
		op_minmax: nxt_o = minmax_o;
		op_mul:    nxt_o = prod_lo;
		op_mulu:   nxt_o = prod_lo;
		op_mulh:   nxt_o = prod_hi;
		op_div:
		begin
			nxt_o = div_q;
			if (div_dbz)
				nxt_exc = flt_dbz;
		end
		op_mod:    nxt_o = div_r;
		op_divu:   nxt_o = div_q;
		op_modu:   nxt_o = div_r;
		op_chk:
		begin
			// a passes through, the rule only decides the cause
			nxt_o = a;
			case (sub)
			3'd0:
				if (flags_ab[flag_ltu] || !flags_ac[flag_ltu])
					nxt_exc = cause;
			3'd1:
				if (flags_ab[flag_ltu] || !flags_ac[flag_leu])
					nxt_exc = cause;
			3'd2:
				if (flags_ac[flag_ne])
					nxt_exc = cause;
			default: nxt_exc = flt_unimp;
			endcase
		end
		op_addi:   nxt_o = a + i;
		op_mov:    nxt_o = a;
		// Copies the old target value
		op_nop:    nxt_o = t;
		default:   nxt_o = dead_word;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o <= '0;
			exc_o <= flt_none;
		end
		else
		begin
			o <= nxt_o;
			exc_o <= nxt_exc;
		end
	end

endmodule

//--- src/alu_div.sv
// Restoring radix-2 divider, one quotient bit per clk
// done drops on the ld edge and rises xlen+2 edges later; ld while busy restarts
// Divide by zero yields an all-ones quotient and the dividend as remainder
`timescale 1ns/1ns

module alu_div (
	input logic clk,
	input logic rst,
	input logic ld,
	input logic sgn,
	input logic [alu_pkg::xlen-1:0] a,
	input logic [alu_pkg::xlen-1:0] b,
	output logic [alu_pkg::xlen-1:0] q,
	output logic [alu_pkg::xlen-1:0] r,
	output logic dbz,
	output logic done
);
	import alu_pkg::*;

	logic busy;
	logic [div_cnt_w-1:0] cnt;
	logic [xlen-1:0] a_mag;
	logic [xlen-1:0] b_mag;
	logic [xlen-1:0] quo;
	logic [xlen-1:0] rem;
	logic [xlen-1:0] dvs;
	logic [xlen:0] shifted;
	logic [xlen+1:0] trial;
	logic q_neg;
	logic r_neg;

	// Magnitudes of the operands in signed mode
	assign a_mag = (sgn && a[xlen-1]) ? -a : a;
	assign b_mag = (sgn && b[xlen-1]) ? -b : b;

	// Partial remainder shifted left with the next dividend bit
	assign shifted = {rem, quo[xlen-1]};
	// Extra top bit is the borrow of the trial subtraction
	assign trial = {1'b0, shifted} - {2'b00, dvs};

	// ========================================
	// Control
	// ========================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			done <= 1'b1;
			dbz <= 1'b0;
			cnt <= '0;
		end
		else if (ld)
		begin
			busy <= 1'b1;
			done <= 1'b0;
			dbz <= (b == '0);
			cnt <= '0;
		end
		else if (busy)
		begin
			cnt <= cnt + 1'b1;
			// Last count follows the sign fix cycle
			if (cnt == xlen + 1)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// ========================================
	// Datapath
	// ========================================
	always_ff @(posedge clk)
	begin
		if (ld)
		begin
			quo <= a_mag;
			rem <= '0;
			dvs <= b_mag;
			// Quotient truncates toward zero, remainder follows the dividend
			q_neg <= sgn & (a[xlen-1] ^ b[xlen-1]);
			r_neg <= sgn & a[xlen-1];
		end
		else if (busy && cnt < xlen)
		begin
			// Keep the difference only when no borrow
			if (!trial[xlen+1])
			begin
				rem <= trial[xlen-1:0];
				quo <= {quo[xlen-2:0], 1'b1};
			end
			else
			begin
				rem <= shifted[xlen-1:0];
				quo <= {quo[xlen-2:0], 1'b0};
			end
		end
		else if (busy && cnt == xlen)
		begin
			// Sign fix; a zero divisor leaves |a| in rem so r returns a
			q <= dbz ? '1 : (q_neg ? -quo : quo);
			r <= r_neg ? -rem : rem;
		end
	end

endmodule

//--- src/alu_mul.sv
// Operands and sgn must be held from ld until mul_done rises
// mul_done drops on the ld edge and is set by the mul_latency-th edge after it
// A new ld only restarts the counter, products already in flight keep moving
`timescale 1ns/1ns

module alu_mul (
	input logic clk,
	input logic rst,
	input logic ld,
	input logic sgn,
	input logic [alu_pkg::xlen-1:0] a,
	input logic [alu_pkg::xlen-1:0] b,
	output logic [alu_pkg::xlen-1:0] prod_lo,
	output logic [alu_pkg::xlen-1:0] prod_hi,
	output logic mul_done
);
	import alu_pkg::*;

	logic signed [xlen:0] ax;
	logic signed [xlen:0] bx;
	logic signed [2*xlen+1:0] p2;
	logic [2*xlen-1:0] p3;
	logic [mul_latency-1:0] cnt;

	// Stage 1 extends by one bit so one signed multiply serves both modes
	// Stage 2 multiplies, stage 3 holds the 128-bit product
	always_ff @(posedge clk)
	begin
		ax <= {sgn & a[xlen-1], a};
		bx <= {sgn & b[xlen-1], b};
		p2 <= ax * bx;
		p3 <= p2[2*xlen-1:0];
	end

	// Shift counter fills with ones, top bit marks completion
	always_ff @(posedge clk)
	begin
		if (rst || ld)
			cnt <= '0;
		else
			cnt <= {cnt[mul_latency-2:0], 1'b1};
	end

	assign mul_done = cnt[mul_latency-1];
	assign prod_lo = p3[xlen-1:0];
	assign prod_hi = p3[2*xlen-1:xlen];

endmodule

//--- src/alu_cmp.sv
// Purely combinational; flags are valid in the same cycle as a and b
// Signed flags treat both operands as two's complement
`timescale 1ns/1ns

module alu_cmp (
	input logic [alu_pkg::xlen-1:0] a,
	input logic [alu_pkg::xlen-1:0] b,
	output logic [7:0] flags
);
	import alu_pkg::*;

	logic [xlen:0] diff_u;
	logic [xlen:0] diff_s;
	logic eq;

	// Unsigned borrow comes out of the zero-extended difference
	assign diff_u = {1'b0, a} - {1'b0, b};
	// Sign of the sign-extended difference gives signed less-than
	assign diff_s = {a[xlen-1], a} - {b[xlen-1], b};
	assign eq = (diff_u[xlen-1:0] == '0);

	always_comb
	begin
		flags[flag_eq]  = eq;
		flags[flag_ne]  = !eq;
		flags[flag_lt]  = diff_s[xlen];
		flags[flag_le]  = diff_s[xlen] | eq;
		flags[flag_ltu] = diff_u[xlen];
		flags[flag_leu] = diff_u[xlen] | eq;
		// Greater forms are the complements of the signed less forms
		flags[flag_gt]  = !(diff_s[xlen] | eq);
		flags[flag_ge]  = !diff_s[xlen];
	end

endmodule

//--- src/alu_pkg.sv
// Shared widths, operation codes and cause codes of the integer execution lane
// The data width is fixed at 64 bits; the shift amount width follows from it
// Cause values other than the named ones come from the lane's cause port
package alu_pkg;

	// ========================================
	// Widths and timing
	// ========================================
	localparam int xlen = 64;
	localparam int shamt_w = $clog2(xlen);
	// Cycles from the ld edge to mul_done rising
	localparam int mul_latency = 4;
	// Divider counter spans load, xlen steps, sign fix and completion
	localparam int div_cnt_w = $clog2(xlen + 2);

	// ========================================
	// Operation and sub-function codes
	// ========================================
	typedef enum logic [4:0] {
		op_add3, op_sub, op_and3, op_or3, op_eor3,
		op_cmp,
		op_shl, op_shr, op_asr,
		op_set, op_zset,
		op_minmax,
		op_mul, op_mulu, op_mulh,
		op_div, op_mod, op_divu, op_modu,
		op_chk,
		op_addi, op_mov, op_nop
	} alu_op_t;

	// Condition selected by sub for set and zset
	typedef enum logic [2:0] {
		cond_eq, cond_ne, cond_lt, cond_le, cond_ltu, cond_leu
	} cond_t;

	// How c joins the a/b result of a three-input op
	typedef enum logic [1:0] {
		comb_and, comb_or, comb_xor, comb_add
	} comb_t;

	// Bit positions in the compare flag word
	localparam int flag_eq  = 0;
	localparam int flag_ne  = 1;
	localparam int flag_lt  = 2;
	localparam int flag_le  = 3;
	localparam int flag_ltu = 4;
	localparam int flag_leu = 5;
	localparam int flag_gt  = 6;
	localparam int flag_ge  = 7;

	// ========================================
	// Exception causes and fill pattern
	// ========================================
	typedef logic [7:0] cause_t;
	localparam cause_t flt_none  = 8'h00;
	localparam cause_t flt_unimp = 8'h25;
	localparam cause_t flt_dbz   = 8'h30;

	// Returned for undefined operations
	localparam logic [xlen-1:0] dead_word = {(xlen / 16){16'hDEAD}};

endpackage
